// ==== logic/bus_pkg.sv ====
// AHB-lite and APB bus types

package bus_pkg;

   // --------------------------------------------------
   // AHB-lite encodings
   // --------------------------------------------------

   // Transfer type on htrans
   typedef enum logic [1:0] {
      IDLE   = 2'b00,
      BUSY   = 2'b01,
      NONSEQ = 2'b10,
      SEQ    = 2'b11
   } htrans_t;

   // Slave response on hresp
   typedef enum logic [1:0] {
      OKAY  = 2'b00,
      ERROR = 2'b01
   } hresp_t;

   // Address phase request, wdata belongs to the data phase
   typedef struct packed {
      logic        sel;
      logic [31:0] addr;
      htrans_t     trans;
      logic        write;
      logic [31:0] wdata;
   } ahb_req_t;

   // Slave response back to the master
   typedef struct packed {
      logic [31:0] rdata;
      logic        ready;
      hresp_t      resp;
   } ahb_rsp_t;

   // --------------------------------------------------
   // APB segment
   // --------------------------------------------------

   // Shared request, common to every slot
   typedef struct packed {
      logic [31:0] paddr;
      logic        pwrite;
      logic        penable;
      logic [31:0] pwdata;
   } apb_req_t;

   // Per slot response
   typedef struct packed {
      logic [31:0] prdata;
      logic        pready;
   } apb_rsp_t;

endpackage

// ==== logic/periph_map_pkg.sv ====
// Peripheral address map

package periph_map_pkg;

   import bus_pkg::*;

   // --------------------------------------------------
   // Slot layout
   // --------------------------------------------------

   // ALUT in slot 0, MACs in slots 1 to 4
   localparam int NUM_SLOTS  = 5;
   localparam int NUM_MACS   = 4;
   localparam int SLOT_IDX_W = $clog2(NUM_SLOTS);

   // 64 KB windows from the base upwards
   localparam logic [31:0] SLOT_BASE  = 32'h00A0_0000;
   localparam int          SLOT_SHIFT = 16;

   typedef logic [NUM_SLOTS-1:0] slot_sel_t;
   typedef logic [NUM_MACS-1:0]  mac_sel_t;

   // One response per MAC, index 0 is slot 1
   typedef apb_rsp_t [NUM_MACS-1:0] mac_rsp_vec_t;

   // --------------------------------------------------
   // ALUT register map
   // --------------------------------------------------

   localparam int ALUT_ENTRIES = 16;
   localparam int ALUT_IDX_W   = $clog2(ALUT_ENTRIES);

   // Offsets inside slot 0, table sits below the key
   localparam logic [SLOT_SHIFT-1:0] ALUT_KEY_ADDR    = 16'h0040;
   localparam logic [SLOT_SHIFT-1:0] ALUT_RESULT_ADDR = 16'h0044;

endpackage

// ==== logic/ahb_to_apb_bridge.sv ====
// AHB-lite to APB bridge
`timescale 1ns/1ns

module ahb_to_apb_bridge
   import bus_pkg::*;
(
   input  logic     hclk,
   input  logic     rst,
   input  ahb_req_t ahb_req,
   input  logic     hready_in,
   input  logic     addr_hit,
   input  apb_rsp_t apb_rsp,
   output ahb_rsp_t ahb_rsp,
   output apb_req_t apb_req,
   output logic     apb_active
);

   typedef enum logic [2:0] {
      st_idle,
      st_setup,
      st_access,
      st_err1,
      st_err2
   } state_t;

   state_t      state_q;
   state_t      state_nxt;
   // Effective state after address decode
   state_t      phase;
   logic        accept;
   logic [31:0] addr_q;
   logic        write_q;
   logic [31:0] wdata_q;
   logic [31:0] rdata_q;

   // --------------------------------------------------
   // Transfer acceptance and state
   // --------------------------------------------------

   // Valid address phase while the bus is ready
   assign accept = ahb_req.sel && hready_in && ahb_rsp.ready &&
                   (ahb_req.trans == NONSEQ || ahb_req.trans == SEQ);

   // Unmapped address turns the setup slot into the first error cycle
   assign phase = (state_q == st_setup && !addr_hit) ? st_err1 : state_q;

   always_comb begin
      state_nxt = state_q;
      case (phase)
         st_idle: begin
            if (accept) begin
               state_nxt = st_setup;
            end
         end
         st_setup: begin
            state_nxt = st_access;
         end
         // Slave wait states keep us here
         st_access: begin
            if (apb_rsp.pready) begin
               state_nxt = st_idle;
            end
         end
         st_err1: begin
            state_nxt = st_err2;
         end
         // Ready is high again so a new transfer may start
         st_err2: begin
            state_nxt = accept ? st_setup : st_idle;
         end
         default: begin
            state_nxt = st_idle;
         end
      endcase
   end

   always_ff @(posedge hclk) begin
      if (rst) begin
         state_q <= st_idle;
      end else begin
         state_q <= state_nxt;
      end
   end

   // --------------------------------------------------
   // Address, write data and read data capture
   // --------------------------------------------------

   always_ff @(posedge hclk) begin
      if (accept) begin
         addr_q  <= ahb_req.addr;
         write_q <= ahb_req.write;
      end
      // Data phase wdata held for the access cycles
      if (phase == st_setup) begin
         wdata_q <= ahb_req.wdata;
      end
      if (phase == st_access && apb_rsp.pready) begin
         rdata_q <= apb_rsp.prdata;
      end
   end

   // --------------------------------------------------
   // Outputs
   // --------------------------------------------------

   assign apb_active = (phase == st_setup) || (phase == st_access);

   always_comb begin
      apb_req.paddr   = addr_q;
      apb_req.pwrite  = write_q;
      apb_req.penable = (state_q == st_access);
      // Live wdata in setup and the captured copy after
      apb_req.pwdata  = (state_q == st_setup) ? ahb_req.wdata : wdata_q;
   end

   always_comb begin
      ahb_rsp.rdata = rdata_q;
      ahb_rsp.ready = (phase == st_idle) || (phase == st_err2);
      ahb_rsp.resp  = (phase == st_err1 || phase == st_err2) ? ERROR : OKAY;
   end

   // Access always follows a setup cycle
   a_penable_after_setup: assert property (@(posedge hclk) disable iff (rst)
      apb_req.penable |-> apb_active && $past(apb_active))
      else $error("penable without a preceding setup cycle");

   // Request held steady across slave wait states
   a_req_stable: assert property (@(posedge hclk) disable iff (rst)
      (phase == st_access && !apb_rsp.pready) |=>
         $stable(apb_req.paddr) && $stable(apb_req.pwrite) && $stable(apb_req.pwdata))
      else $error("APB request changed during wait state");

endmodule

// ==== logic/apb_slot_decoder.sv ====
// APB slot decoder
`timescale 1ns/1ns

module apb_slot_decoder
   import bus_pkg::*;
   import periph_map_pkg::*;
(
   input  apb_req_t     apb_req,
   input  logic         apb_active,
   input  apb_rsp_t     alut_rsp,
   input  mac_rsp_vec_t mac_rsp,
   output slot_sel_t    slot_sel,
   output logic         addr_hit,
   output apb_rsp_t     apb_rsp
);

   // Window number relative to slot 0
   logic [31-SLOT_SHIFT:0] slot_off;
   logic [SLOT_IDX_W-1:0]  slot_idx;

   // --------------------------------------------------
   // Address decode
   // --------------------------------------------------

   assign slot_off = apb_req.paddr[31:SLOT_SHIFT] - SLOT_BASE[31:SLOT_SHIFT];
   assign slot_idx = slot_off[SLOT_IDX_W-1:0];
   // Below the base wraps high and misses too
   assign addr_hit = (slot_off < (32-SLOT_SHIFT)'(NUM_SLOTS));

   // Selects only during setup and access
   assign slot_sel = (apb_active && addr_hit) ? (slot_sel_t'(1) << slot_idx) : '0;

   // --------------------------------------------------
   // Response steering
   // --------------------------------------------------

   always_comb begin
      // Idle bus reads as ready with zero data
      apb_rsp.prdata = '0;
      apb_rsp.pready = 1'b1;
      if (slot_sel[0]) begin
         apb_rsp = alut_rsp;
      end
      for (int m = 0; m < NUM_MACS; m++) begin
         if (slot_sel[m+1]) begin
            apb_rsp = mac_rsp[m];
         end
      end
   end

endmodule

// ==== logic/alut_regs.sv ====
// Address lookup table registers
`timescale 1ns/1ns

module alut_regs
   import bus_pkg::*;
   import periph_map_pkg::*;
(
   input  logic     hclk,
   input  logic     rst,
   input  logic     psel,
   input  apb_req_t apb_req,
   output apb_rsp_t apb_rsp
);

   logic [ALUT_ENTRIES-1:0][31:0] entry_q;
   logic [31:0]                   key_q;
   // Word aligned offset inside the slot
   logic [SLOT_SHIFT-1:0]         word_off;
   logic [ALUT_IDX_W-1:0]         entry_idx;
   logic                          is_entry;
   logic                          is_key;
   logic                          is_result;
   logic                          wr_en;
   logic                          lookup_hit;
   logic [ALUT_IDX_W-1:0]         lookup_idx;
   logic [31:0]                   result;

   // --------------------------------------------------
   // Register decode
   // --------------------------------------------------

   assign word_off  = {apb_req.paddr[SLOT_SHIFT-1:2], 2'b00};
   assign entry_idx = word_off[ALUT_IDX_W+1:2];
   // Table occupies the lowest words
   assign is_entry  = (word_off[SLOT_SHIFT-1:ALUT_IDX_W+2] == '0);
   assign is_key    = (word_off == ALUT_KEY_ADDR);
   assign is_result = (word_off == ALUT_RESULT_ADDR);

   // Write lands on the access edge
   assign wr_en = psel && apb_req.penable && apb_req.pwrite;

   always_ff @(posedge hclk) begin
      if (rst) begin
         entry_q <= '0;
         key_q   <= '0;
      end else if (wr_en) begin
         if (is_entry) begin
            entry_q[entry_idx] <= apb_req.pwdata;
         end
         if (is_key) begin
            key_q <= apb_req.pwdata;
         end
      end
   end

   // --------------------------------------------------
   // Lookup
   // --------------------------------------------------

   // Scan downwards so the lowest match wins
   always_comb begin
      lookup_hit = 1'b0;
      lookup_idx = '0;
      for (int i = ALUT_ENTRIES - 1; i >= 0; i--) begin
         if (entry_q[i] == key_q) begin
            lookup_hit = 1'b1;
            lookup_idx = ALUT_IDX_W'(i);
         end
      end
   end

   // Hit flag on top and index in the low bits
   assign result = {lookup_hit, {(31-ALUT_IDX_W){1'b0}}, lookup_idx};

   // Combinational read that never waits
   always_comb begin
      apb_rsp.pready = 1'b1;
      if (is_entry) begin
         apb_rsp.prdata = entry_q[entry_idx];
      end else if (is_key) begin
         apb_rsp.prdata = key_q;
      end else if (is_result) begin
         apb_rsp.prdata = result;
      end else begin
         apb_rsp.prdata = '0;
      end
   end

   // Write access comes right after its own setup cycle
   a_wr_after_setup: assert property (@(posedge hclk) disable iff (rst)
      wr_en |-> $past(psel && !apb_req.penable && apb_req.pwrite))
      else $error("ALUT write without a preceding setup cycle");

endmodule

// ==== logic/apb_subsystem.sv ====
// APB peripheral subsystem top
`timescale 1ns/1ns

module apb_subsystem
   import bus_pkg::*;
   import periph_map_pkg::*;
(
   // AHB-lite slave side
   input  logic         hclk,
   input  logic         rst,
   input  ahb_req_t     ahb_req,
   input  logic         hready_in,
   output ahb_rsp_t     ahb_rsp,

   // Shared APB request to the MACs
   output apb_req_t     apb_req,

   // MAC selects and responses
   output mac_sel_t     mac_psel,
   input  mac_rsp_vec_t mac_rsp
);

   // Decode result for the registered address
   logic      addr_hit;
   // Setup or access in progress
   logic      apb_active;
   // Response of the selected slot
   apb_rsp_t  slot_rsp;
   // ALUT slot response
   apb_rsp_t  alut_rsp;
   // One-hot select, bit 0 is the ALUT
   slot_sel_t slot_sel;

   // --------------------------------------------------
   // Bridge
   // --------------------------------------------------

   ahb_to_apb_bridge i_bridge (
      .hclk       (hclk),
      .rst        (rst),
      .ahb_req    (ahb_req),
      .hready_in  (hready_in),
      .addr_hit   (addr_hit),
      .apb_rsp    (slot_rsp),
      .ahb_rsp    (ahb_rsp),
      .apb_req    (apb_req),
      .apb_active (apb_active)
   );

   // --------------------------------------------------
   // Slot decode and response steering
   // --------------------------------------------------

   apb_slot_decoder i_decoder (
      .apb_req    (apb_req),
      .apb_active (apb_active),
      .alut_rsp   (alut_rsp),
      .mac_rsp    (mac_rsp),
      .slot_sel   (slot_sel),
      .addr_hit   (addr_hit),
      .apb_rsp    (slot_rsp)
   );

   // MAC selects leave the subsystem
   assign mac_psel = slot_sel[NUM_SLOTS-1:1];

   // --------------------------------------------------
   // ALUT register block
   // --------------------------------------------------

   alut_regs i_alut (
      .hclk    (hclk),
      .rst     (rst),
      .psel    (slot_sel[0]),
      .apb_req (apb_req),
      .apb_rsp (alut_rsp)
   );

endmodule

// ==== verification/tb_apb_subsystem.sv ====
// APB subsystem directed testbench
`timescale 1ns/1ns

module tb_apb_subsystem
   import bus_pkg::*;
   import periph_map_pkg::*;
();

   localparam int TIMEOUT = 20;

   logic         hclk;
   logic         rst;
   ahb_req_t     ahb_req;
   logic         hready_in;
   ahb_rsp_t     ahb_rsp;
   apb_req_t     apb_req;
   mac_sel_t     mac_psel;
   mac_rsp_vec_t mac_rsp;

   // MAC slave model state
   logic [31:0] mac_mem [NUM_MACS][16];
   int          wait_left [NUM_MACS];
   int          last_wait;
   int          draw;
   int          seed = 32'h62d3;

   // Per-transfer observations
   int       low_cycles;
   mac_sel_t psel_seen;
   logic     penable_seen;
   int       errors = 0;
   int       checks = 0;

   apb_subsystem dut0 (
      .hclk      (hclk),
      .rst       (rst),
      .ahb_req   (ahb_req),
      .hready_in (hready_in),
      .ahb_rsp   (ahb_rsp),
      .apb_req   (apb_req),
      .mac_psel  (mac_psel),
      .mac_rsp   (mac_rsp)
   );

   initial begin
      hclk = 1'b0;
      forever #50 hclk = ~hclk;
   end

   // --------------------------------------------------
   // MAC slave models
   // --------------------------------------------------

   // Reset contents encode slot and byte offset
   function automatic logic [31:0] mac_fill(int m, int idx);
      return 32'hF000_0000 | ((m + 1) << 16) | (idx << 2);
   endfunction

   function automatic logic [31:0] mac_addr(int m, int idx);
      return SLOT_BASE + ((m + 1) << SLOT_SHIFT) + idx * 4;
   endfunction

   always @(posedge hclk) begin
      if (rst) begin
         for (int m = 0; m < NUM_MACS; m++) begin
            wait_left[m] <= 0;
            for (int i = 0; i < 16; i++) begin
               mac_mem[m][i] <= mac_fill(m, i);
            end
         end
      end else begin
         for (int m = 0; m < NUM_MACS; m++) begin
            // Setup cycle picks the wait count, 0 to 3
            if (mac_psel[m] && !apb_req.penable) begin
               draw = $unsigned($random(seed)) % 4;
               wait_left[m] <= draw;
               last_wait    <= draw;
            end else if (mac_psel[m] && wait_left[m] > 0) begin
               wait_left[m] <= wait_left[m] - 1;
            end else if (mac_psel[m] && apb_req.pwrite) begin
               mac_mem[m][apb_req.paddr[5:2]] <= apb_req.pwdata;
            end
         end
      end
   end

   always_comb begin
      for (int m = 0; m < NUM_MACS; m++) begin
         mac_rsp[m].prdata = mac_mem[m][apb_req.paddr[5:2]];
         mac_rsp[m].pready = (wait_left[m] == 0);
      end
   end

   // --------------------------------------------------
   // Compare tasks and AHB driver
   // --------------------------------------------------

   task automatic check_data(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_resp(input string name, input hresp_t got, input hresp_t exp);
      checks++;
      if (got !== exp) begin
         $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
         errors++;
      end
   endtask

   task automatic ahb_transfer(input logic wr, input logic [31:0] addr,
                               input logic [31:0] data, output logic [31:0] rdata,
                               output hresp_t resp);
      int cycles;
      cycles = 0;
      @(negedge hclk);
      while (!ahb_rsp.ready && cycles < TIMEOUT) begin
         @(negedge hclk);
         cycles++;
      end
      if (!ahb_rsp.ready) begin
         $display("Timeout: bus not ready for the address phase at 0x%h", addr);
         errors++;
      end
      // Address phase
      ahb_req.sel   = 1'b1;
      ahb_req.addr  = addr;
      ahb_req.trans = NONSEQ;
      ahb_req.write = wr;
      @(negedge hclk);
      // Data phase, write data follows acceptance
      ahb_req.sel   = 1'b0;
      ahb_req.trans = IDLE;
      ahb_req.write = 1'b0;
      ahb_req.wdata = data;
      low_cycles    = 0;
      psel_seen     = '0;
      penable_seen  = 1'b0;
      while (!ahb_rsp.ready && low_cycles < TIMEOUT) begin
         psel_seen    = psel_seen | mac_psel;
         penable_seen = penable_seen | apb_req.penable;
         low_cycles++;
         @(negedge hclk);
      end
      if (!ahb_rsp.ready) begin
         $display("Timeout: ready stayed low after the transfer to 0x%h", addr);
         errors++;
      end
      rdata = ahb_rsp.rdata;
      resp  = ahb_rsp.resp;
   endtask

   task automatic ahb_write(input logic [31:0] addr, input logic [31:0] data,
                            output hresp_t resp);
      logic [31:0] unused;
      ahb_transfer(1'b1, addr, data, unused, resp);
   endtask

   task automatic ahb_read(input logic [31:0] addr, output logic [31:0] data,
                           output hresp_t resp);
      ahb_transfer(1'b0, addr, 32'h0, data, resp);
   endtask

   task automatic end_test(input string name, input int errs_at_start);
      $display("%s: %0d error(s)", name, errors - errs_at_start);
   endtask

   // --------------------------------------------------
   // Tests
   // --------------------------------------------------

   task automatic reset_defaults();
      int e0;
      e0 = errors;
      @(negedge hclk);
      check_data("ahb_rsp.ready", 32'(ahb_rsp.ready), 32'h1);
      check_resp("ahb_rsp.resp", ahb_rsp.resp, OKAY);
      check_data("apb_req.penable", 32'(apb_req.penable), 32'h0);
      check_data("mac_psel", 32'(mac_psel), 32'h0);
      end_test("reset_defaults", e0);
   endtask

   task automatic mac_round_trip();
      int          e0;
      int          offs [3];
      logic [31:0] rd;
      hresp_t      rs;
      e0   = errors;
      offs = '{0, 5, 15};
      for (int m = 0; m < NUM_MACS; m++) begin
         foreach (offs[k]) begin
            ahb_write(mac_addr(m, offs[k]), 32'h5A00_0000 ^ (m << 12) ^ offs[k], rs);
            check_resp("hresp write", rs, OKAY);
            check_data("mac_psel", 32'(psel_seen), 32'(1 << m));
         end
      end
      for (int m = 0; m < NUM_MACS; m++) begin
         foreach (offs[k]) begin
            ahb_read(mac_addr(m, offs[k]), rd, rs);
            check_resp("hresp read", rs, OKAY);
            check_data("hrdata", rd, 32'h5A00_0000 ^ (m << 12) ^ offs[k]);
            check_data("mac_psel", 32'(psel_seen), 32'(1 << m));
         end
      end
      end_test("mac_round_trip", e0);
   endtask

   task automatic alut_table_rw();
      int          e0;
      logic [31:0] rd;
      hresp_t      rs;
      e0 = errors;
      for (int i = 0; i < ALUT_ENTRIES; i++) begin
         ahb_write(SLOT_BASE + i * 4, 32'h1234_0000 + i * 32'h1111, rs);
         check_resp("hresp write", rs, OKAY);
      end
      ahb_write(SLOT_BASE + 32'(ALUT_KEY_ADDR), 32'hDEAD_BEEF, rs);
      for (int i = 0; i < ALUT_ENTRIES; i++) begin
         ahb_read(SLOT_BASE + i * 4, rd, rs);
         check_data("alut entry", rd, 32'h1234_0000 + i * 32'h1111);
      end
      ahb_read(SLOT_BASE + 32'(ALUT_KEY_ADDR), rd, rs);
      check_data("alut key", rd, 32'hDEAD_BEEF);
      // No MAC select for slot 0
      check_data("mac_psel", 32'(psel_seen), 32'h0);
      end_test("alut_table_rw", e0);
   endtask

   task automatic alut_lookup();
      int          e0;
      logic [31:0] rd;
      hresp_t      rs;
      e0 = errors;
      // Same key at 11 and 5, lower index expected
      ahb_write(SLOT_BASE + 11 * 4, 32'h0BAD_F00D, rs);
      ahb_write(SLOT_BASE + 5 * 4, 32'h0BAD_F00D, rs);
      ahb_write(SLOT_BASE + 32'(ALUT_KEY_ADDR), 32'h0BAD_F00D, rs);
      ahb_read(SLOT_BASE + 32'(ALUT_RESULT_ADDR), rd, rs);
      check_data("alut result", rd, 32'h8000_0005);
      // Miss reads as all zero
      ahb_write(SLOT_BASE + 32'(ALUT_KEY_ADDR), 32'h7777_7777, rs);
      ahb_read(SLOT_BASE + 32'(ALUT_RESULT_ADDR), rd, rs);
      check_data("alut result", rd, 32'h0);
      end_test("alut_lookup", e0);
   endtask

   task automatic unmapped_access();
      int          e0;
      logic [31:0] rd;
      hresp_t      rs;
      e0 = errors;
      ahb_read(32'h00A5_0000, rd, rs);
      check_resp("hresp", rs, ERROR);
      check_data("ready_low_cycles", low_cycles, 32'h1);
      check_data("mac_psel", 32'(psel_seen), 32'h0);
      check_data("apb_req.penable", 32'(penable_seen), 32'h0);
      ahb_write(32'h0000_1000, 32'h1111_2222, rs);
      check_resp("hresp", rs, ERROR);
      check_data("mac_psel", 32'(psel_seen), 32'h0);
      check_data("apb_req.penable", 32'(penable_seen), 32'h0);
      // Bus recovers for the next mapped access
      ahb_read(SLOT_BASE + 32'(ALUT_KEY_ADDR), rd, rs);
      check_resp("hresp", rs, OKAY);
      check_data("alut key", rd, 32'h7777_7777);
      end_test("unmapped_access", e0);
   endtask

   task automatic back_pressure_reads();
      int          e0;
      int          m;
      int          idx;
      logic [31:0] rd;
      hresp_t      rs;
      e0 = errors;
      // Offsets 1 to 4 still hold their reset fill
      for (int n = 0; n < 8; n++) begin
         m   = $unsigned($random(seed)) % NUM_MACS;
         idx = 1 + $unsigned($random(seed)) % 4;
         ahb_read(mac_addr(m, idx), rd, rs);
         check_resp("hresp", rs, OKAY);
         check_data("hrdata", rd, mac_fill(m, idx));
         checks++;
         if (low_cycles < 2 + last_wait) begin
            $display("Ready was low for %0d cycles with %0d wait states inserted",
                     low_cycles, last_wait);
            errors++;
         end
      end
      end_test("back_pressure_reads", e0);
   endtask

   // --------------------------------------------------
   // Sequence
   // --------------------------------------------------

   initial begin
      rst       = 1'b1;
      hready_in = 1'b1;
      ahb_req   = '0;
      repeat (2) @(negedge hclk);
      rst = 1'b0;
      reset_defaults();
      mac_round_trip();
      alut_table_rw();
      alut_lookup();
      unmapped_access();
      back_pressure_reads();
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// ==== files.f ====
logic/bus_pkg.sv
logic/periph_map_pkg.sv
logic/ahb_to_apb_bridge.sv
logic/apb_slot_decoder.sv
logic/alut_regs.sv
logic/apb_subsystem.sv
verification/tb_apb_subsystem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the APB subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_apb_subsystem -f files.f \
   -o sim_apb_subsystem || exit 1
out="$(./obj_dir/sim_apb_subsystem)"
echo "$out"
echo "$out" | grep -qx "Finished with no errors" && exit 0 || exit 1
